/* logic/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [15:0] word_t;    // memory and register word
  typedef logic [5:0]  addr_t;    // word address, 64 words
  typedef logic [2:0]  reg_sel_t; // register number

  localparam int mem_words = 64;
  localparam int num_regs  = 8;

  // opcodes live in the high byte of the first instruction word
  typedef enum logic [7:0] {
    op_jmp     = 8'd1,
    op_ram2reg = 8'd2,
    op_reg2ram = 8'd3,
    op_num2reg = 8'd4,
    op_out     = 8'd5
  } opcode_t;

  typedef struct packed {
    logic [7:0] opcode;     // raw byte, may hold an unknown code
    logic [7:0] reg_field;
    word_t      operand;    // second word
  } instr_t;

  typedef struct packed {
    instr_t instr;
    addr_t  pc;             // address of the first word
  } fetch_pkt_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  localparam addr_t      program_start = 6'd16; // words 0..15 hold data
  localparam logic [7:0] error_byte    = 8'h3F; // "?"

endpackage

/* logic/word_mem.sv */
`timescale 1ns/1ps

module word_mem (
  input  logic              clk,
  input  cpu_pkg::addr_t    fetch_addr,
  output cpu_pkg::word_t    fetch_data,
  input  cpu_pkg::mem_req_t mem_req,
  output cpu_pkg::word_t    mem_rdata
);

  cpu_pkg::word_t mem [cpu_pkg::mem_words];

  // data area and program come from the same image
  initial begin
    $readmemh("program.hex", mem);
  end

  // fetch port, read only
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

  // executor port, read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (mem_req.we) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
    mem_rdata <= mem[mem_req.addr];
  end

endmodule

/* logic/fetcher.sv */
`timescale 1ns/1ps

module fetcher (
  input  logic                clk,
  input  logic                exec,
  output cpu_pkg::addr_t      fetch_addr,
  input  cpu_pkg::word_t      fetch_data,
  output cpu_pkg::fetch_pkt_t fetch_pkt,
  output logic                fetch_valid,
  input  logic                fetch_ready,
  input  logic                redirect,
  input  cpu_pkg::addr_t      redirect_pc
);

  typedef enum logic [1:0] {
    st_addr0, // first word address on the bus
    st_addr1, // second word address, first word arriving
    st_data1, // second word arriving
    st_park   // both words kept, waiting for the holding register
  } fstate_t;

  fstate_t             state;
  cpu_pkg::addr_t      pc;
  cpu_pkg::addr_t      ipc;
  cpu_pkg::word_t      word0;
  cpu_pkg::word_t      word1;
  cpu_pkg::word_t      second;
  cpu_pkg::fetch_pkt_t hold;
  logic                hold_valid;
  logic                slot_free;
  logic                load_hold;

  assign fetch_addr  = pc;
  assign fetch_pkt   = hold;
  assign fetch_valid = hold_valid;

  assign slot_free = !hold_valid || fetch_ready; // empty, or handed over this edge
  assign second    = (state == st_park) ? word1 : fetch_data;
  assign load_hold = (state == st_data1 || state == st_park) && slot_free && !redirect;

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      state      <= st_addr0;
      pc         <= cpu_pkg::program_start;
      hold_valid <= 1'b0;
    end else if (redirect) begin
      // jump taken, drop the held and the half fetched instruction
      state      <= st_addr0;
      pc         <= redirect_pc;
      hold_valid <= 1'b0;
    end else begin
      if (load_hold) begin
        hold_valid <= 1'b1;
      end else if (fetch_ready) begin
        hold_valid <= 1'b0;
      end
      case (state)
        st_addr0: begin
          pc    <= pc + 6'd1;
          state <= st_addr1;
        end
        st_addr1: begin
          pc    <= pc + 6'd1;
          state <= st_data1;
        end
        st_data1: state <= slot_free ? st_addr0 : st_park;
        st_park:  if (slot_free) state <= st_addr0;
        default:  state <= st_addr0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_addr0) ipc <= pc;
    if (state == st_addr1) word0 <= fetch_data;
    if (state == st_data1) word1 <= fetch_data;  // kept in case we park
    if (load_hold) begin
      hold.instr <= {word0, second};
      hold.pc    <= ipc;
    end
  end

endmodule

/* logic/executor.sv */
`timescale 1ns/1ps

module executor (
  input  logic                clk,
  input  logic                exec,
  input  cpu_pkg::fetch_pkt_t fetch_pkt,
  input  logic                fetch_valid,
  output logic                fetch_ready,
  output logic                redirect,
  output cpu_pkg::addr_t      redirect_pc,
  output cpu_pkg::mem_req_t   mem_req,
  input  cpu_pkg::word_t      mem_rdata,
  output logic [7:0]          out_byte,
  output logic                out_valid,
  input  logic                out_ready
);

  cpu_pkg::word_t    regs [cpu_pkg::num_regs];
  cpu_pkg::instr_t   cur;        // instruction in progress
  cpu_pkg::opcode_t  op;
  cpu_pkg::reg_sel_t rsel;
  cpu_pkg::addr_t    op_addr;
  logic              busy;
  logic              load_wait;  // second cycle of ram2reg
  logic              accept;
  logic              is_send;

  assign op      = cpu_pkg::opcode_t'(cur.opcode);
  assign rsel    = cur.reg_field[2:0];
  assign op_addr = cur.operand[5:0];
  assign accept  = fetch_valid && fetch_ready;

  assign fetch_ready = !busy;

  // out and every unknown opcode go to the FIFO
  assign is_send = !(op == cpu_pkg::op_jmp     || op == cpu_pkg::op_ram2reg ||
                     op == cpu_pkg::op_reg2ram || op == cpu_pkg::op_num2reg);

  assign redirect    = busy && op == cpu_pkg::op_jmp;
  assign redirect_pc = op_addr;

  assign mem_req.we    = busy && op == cpu_pkg::op_reg2ram;
  assign mem_req.addr  = op_addr;
  assign mem_req.wdata = regs[rsel];

  assign out_valid = busy && is_send;
  assign out_byte  = (op == cpu_pkg::op_out) ? regs[rsel][7:0] : cpu_pkg::error_byte;

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      busy      <= 1'b0;
      load_wait <= 1'b0;
      regs      <= '{default: '0};
    end else if (!busy) begin
      if (accept) busy <= 1'b1;
    end else begin
      case (op)
        cpu_pkg::op_num2reg: begin
          regs[rsel] <= cur.operand;
          busy       <= 1'b0;
        end
        cpu_pkg::op_reg2ram, cpu_pkg::op_jmp: begin
          busy <= 1'b0;  // write or redirect happens this cycle
        end
        cpu_pkg::op_ram2reg: begin
          if (load_wait) begin
            regs[rsel] <= mem_rdata;
            load_wait  <= 1'b0;
            busy       <= 1'b0;
          end else begin
            load_wait <= 1'b1;  // read data comes next cycle
          end
        end
        default: begin
          if (out_ready) busy <= 1'b0;  // stalls while the FIFO is full
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) cur <= fetch_pkt.instr;
  end

endmodule

/* logic/tx_fifo.sv */
`timescale 1ns/1ps

module tx_fifo #(
  parameter int depth = 16
) (
  input  logic       clk,
  input  logic       exec,
  input  logic [7:0] out_byte,
  input  logic       out_valid,
  output logic       out_ready,
  output logic [7:0] tx_byte,
  output logic       tx_valid,
  input  logic       tx_ready
);

  localparam int aw = $clog2(depth);
  localparam bit [aw:0]   full_cnt = (aw + 1)'(depth);
  localparam bit [aw-1:0] last_ptr = aw'(depth - 1);

  logic [7:0]    fifo_mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;
  logic          push;
  logic          pop;

  assign out_ready = count != full_cnt;
  assign tx_valid  = count != '0;
  assign tx_byte   = fifo_mem[rd_ptr];
  assign push      = out_valid && out_ready;
  assign pop       = tx_valid && tx_ready;

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= out_byte;
  end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

// 8N1, LSB first, line idles high
module uart_tx #(
  parameter int clk_per_bit = 868
) (
  input  logic       clk,
  input  logic       exec,
  input  logic [7:0] tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx
);

  localparam int cw = $clog2(clk_per_bit);
  localparam bit [cw-1:0] last_cnt = cw'(clk_per_bit - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } ustate_t;

  ustate_t       state;
  logic [cw-1:0] cnt;      // cycles into the current bit
  logic [2:0]    bit_idx;
  logic [7:0]    data_q;
  logic          bit_end;

  assign bit_end  = cnt == last_cnt;
  assign tx_ready = state == st_idle;

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      state   <= st_idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        st_idle: begin
          cnt <= '0;
          if (tx_valid) begin
            state <= st_start;
            tx    <= 1'b0;  // start bit
          end
        end
        st_start: if (bit_end) begin
          state   <= st_data;
          bit_idx <= '0;
          tx      <= data_q[0];
        end
        st_data: if (bit_end) begin
          if (bit_idx == 3'd7) begin
            state <= st_stop;
            tx    <= 1'b1;
          end else begin
            bit_idx <= bit_idx + 3'd1;
            tx      <= data_q[bit_idx + 3'd1];
          end
        end
        st_stop: if (bit_end) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && tx_valid) data_q <= tx_byte;
  end

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
  parameter int clk_per_bit = 868,  // 100 MHz at 115200 baud
  parameter int fifo_depth  = 16
) (
  input  logic clk,
  input  logic exec,
  output logic tx
);

  cpu_pkg::addr_t      fetch_addr;
  cpu_pkg::word_t      fetch_data;
  cpu_pkg::mem_req_t   mem_req;
  cpu_pkg::word_t      mem_rdata;
  cpu_pkg::fetch_pkt_t fetch_pkt;
  logic                fetch_valid;
  logic                fetch_ready;
  logic                redirect;
  cpu_pkg::addr_t      redirect_pc;
  logic [7:0]          out_byte;
  logic                out_valid;
  logic                out_ready;
  logic [7:0]          tx_byte;
  logic                tx_valid;
  logic                tx_ready;

  word_mem u_mem (
    .clk        (clk),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .mem_req    (mem_req),
    .mem_rdata  (mem_rdata)
  );

  fetcher u_fetch (
    .clk         (clk),
    .exec        (exec),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_pkt   (fetch_pkt),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  executor u_exec (
    .clk         (clk),
    .exec        (exec),
    .fetch_pkt   (fetch_pkt),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_req     (mem_req),
    .mem_rdata   (mem_rdata),
    .out_byte    (out_byte),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  tx_fifo #(.depth(fifo_depth)) u_fifo (
    .clk       (clk),
    .exec      (exec),
    .out_byte  (out_byte),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready)
  );

  uart_tx #(.clk_per_bit(clk_per_bit)) u_tx (
    .clk      (clk),
    .exec     (exec),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

endmodule

/* tb/cpu_chk.sv */
`timescale 1ns/1ps

module cpu_chk (
  input logic                clk,
  input logic                exec,
  input cpu_pkg::fetch_pkt_t fetch_pkt,
  input logic                fetch_valid,
  input logic                fetch_ready,
  input logic                tx,
  input logic                tx_ready,
  input logic                out_valid,
  input logic                out_ready,
  input logic                redirect
);

  int fail_count = 0;

  // held instruction may not move until the executor takes it
  a_pkt_stable: assert property (@(posedge clk) disable iff (exec)
    fetch_valid && !fetch_ready |=> $stable(fetch_pkt))
    else begin
      $error("fetch_pkt changed while fetch_ready was low");
      fail_count++;
    end

  a_tx_idle: assert property (@(posedge clk) disable iff (exec)
    tx_ready |-> tx)  // tx_ready is high only in the idle state
    else begin
      $error("tx low while the transmitter is idle");
      fail_count++;
    end

  a_out_once: assert property (@(posedge clk) disable iff (exec)
    out_valid && out_ready |=> !out_valid)
    else begin
      $error("out_valid still high after the byte was accepted");
      fail_count++;
    end

  a_redirect_pulse: assert property (@(posedge clk) disable iff (exec)
    redirect |=> !redirect)
    else begin
      $error("redirect held for more than one cycle");
      fail_count++;
    end

endmodule

bind cpu_top cpu_chk u_chk (
  .clk         (clk),
  .exec        (exec),
  .fetch_pkt   (fetch_pkt),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .tx          (tx),
  .tx_ready    (tx_ready),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .redirect    (redirect)
);

/* tb/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

  localparam int clk_per_bit  = 16;
  localparam int fifo_depth   = 4;
  localparam int start_window = 200;  // cycles allowed before a start bit shows up
  localparam int quiet_cycles = 300;
  // 9 frames of 160 cycles plus the quiet check, reset and fetch, with margin
  localparam int max_cycles   = 4000;

  logic clk;
  logic exec;
  logic tx;
  int   mismatch_count;
  int   other_count;
  int   cycle_count;

  cpu_top #(
    .clk_per_bit (clk_per_bit),
    .fifo_depth  (fifo_depth)
  ) UUT (
    .clk  (clk),
    .exec (exec),
    .tx   (tx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: run did not finish within %0d cycles", max_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  // waits for a start bit on tx, then samples each bit near its middle
  task automatic recv_byte(input int window, output logic [7:0] data);
    int waited;
    int b;
    data   = 'x;
    waited = 0;
    while (tx !== 1'b0 && waited < window) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("ERROR: no start bit on tx within %0d cycles", window);
      other_count++;
    end else begin
      repeat (clk_per_bit / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        $display("ERROR: start bit on tx was a glitch");
        other_count++;
      end
      for (b = 0; b < 8; b++) begin
        repeat (clk_per_bit) @(negedge clk);
        data[b] = tx;  // LSB first
      end
      repeat (clk_per_bit) @(negedge clk);
      if (tx !== 1'b1) begin
        $display("ERROR: stop bit on tx was low");
        other_count++;
      end
    end
  endtask

  task automatic idle_after_reset();
    repeat (4) begin
      @(negedge clk);
      check("idle_after_reset", 1'b1, tx);
    end
    exec = 1'b0;  // release on the falling edge
    @(negedge clk);
    check("idle_after_reset", 1'b1, tx);
  endtask

  task automatic num2reg_out();
    logic [7:0] got;
    recv_byte(start_window, got);
    check("num2reg_out", "H", got);
  endtask

  task automatic memory_round_trip();
    logic [7:0] got;
    recv_byte(start_window, got);
    check("memory_round_trip", "i", got);  // stored to word 5 and loaded back
  endtask

  task automatic unknown_opcode();
    logic [7:0] got;
    recv_byte(start_window, got);
    check("unknown_opcode", 8'h3F, got);
  endtask

  task automatic jump_skip();
    logic [7:0] got;
    recv_byte(start_window, got);
    check("jump_skip", "H", got);  // a "Z" here means the jmp fell through
  endtask

  task automatic backpressure_burst();
    int         i;
    logic [7:0] got;
    logic [7:0] want;
    logic       seen;
    for (i = 0; i < 5; i++) begin
      want = 8'h41 + 8'(i);
      recv_byte(start_window, got);
      check("backpressure_burst", want, got);
    end
    // program now spins on a jump to itself
    seen = 1'b0;
    for (i = 0; i < quiet_cycles && !seen; i++) begin
      @(negedge clk);
      if (tx === 1'b0) seen = 1'b1;
    end
    if (seen) begin
      $display("ERROR: tx sent another frame after the last byte");
      other_count++;
    end
  endtask

  initial begin
    exec           = 1'b1;
    mismatch_count = 0;
    other_count    = 0;
    idle_after_reset();
    num2reg_out();
    memory_round_trip();
    unknown_opcode();
    jump_skip();
    backpressure_burst();
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, other_count, UUT.u_chk.fail_count);
    if (mismatch_count == 0 && other_count == 0 && UUT.u_chk.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* list.f */
logic/cpu_pkg.sv
logic/word_mem.sv
logic/fetcher.sv
logic/executor.sv
logic/tx_fifo.sv
logic/uart_tx.sv
logic/cpu_top.sv
tb/cpu_chk.sv
tb/tb_cpu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cpu
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* program.hex */
// one 16-bit hex word per entry, @ lines give the word address
// instructions take two words: opcode and register, then the operand
@00
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
@10
0401 0048  // num2reg r1 = "H"
0501 0000  // out r1
0402 0069  // num2reg r2 = "i"
0302 0005  // reg2ram r2 -> word 5
0203 0005  // ram2reg r3 <- word 5
0503 0000  // out r3
0F00 0000  // unknown opcode, sends "?"
0100 0024  // jmp 36
0401 005A  // num2reg r1 = "Z", skipped
0501 0000  // out r1, skipped
0501 0000  // out r1, sends "H"
0403 0041  // num2reg r3 = "A"
0404 0042  // num2reg r4 = "B"
0405 0043  // num2reg r5 = "C"
0406 0044  // num2reg r6 = "D"
0407 0045  // num2reg r7 = "E"
0503 0000  // out r3
0504 0000  // out r4
0505 0000  // out r5
0506 0000  // out r6
0507 0000  // out r7
0100 003A  // jmp 58, spin here
0000 0000 0000 0000
